//--- common/trace_pkg.sv
/* Widths, packed structs and state enums shared by the trace capture design.
   Every RTL module takes what it needs through a wildcard import in its header. */

`default_nettype none

package trace_pkg;

   typedef logic [3:0] nibble_t;          // one trace port sample
   typedef logic [7:0] byte_t;            // one assembled trace byte

   localparam int BUFFER_BYTES = 4;

   // byte 0 is the newest
   typedef logic [BUFFER_BYTES*8-1:0] buffer_t;

   // seven F nibbles then a 7, oldest nibble in the top bits
   localparam logic [31:0] SYNC_WORD = 32'hffff_fff7;

   typedef struct packed {
      buffer_t pattern;
      buffer_t mask;                      // 1 = bit takes part in the compare
      logic    enable;
      logic    trig_enable;               // hit may start the trigger pulse
   } match_rule_t;

   typedef struct packed {
      logic [15:0] delay;                 // cycles between hit and pulse
      logic [15:0] width;                 // pulse length, 0 acts as 1
   } trigger_cfg_t;

   typedef logic [3:0]  rule_id_t;        // up to 16 rules
   typedef logic [7:0]  hit_count_t;
   typedef logic [15:0] position_t;       // bytes seen since arm rose

   localparam hit_count_t HIT_COUNT_MAX = 8'hff;

   typedef struct packed {
      rule_id_t  rule;
      position_t position;
   } record_t;

   typedef enum logic {
      HUNT,
      SYNCED
   } decode_state_t;

   typedef enum logic [1:0] {
      IDLE,
      DELAY,
      PULSE,
      DONE
   } trigger_state_t;

endpackage

`default_nettype wire

//--- trace_decode/trace_decode.sv
/* Trace port decoder. Hunts for the sync word in the nibble stream, then
   pairs nibbles into bytes, low nibble first, and strobes each byte out. */

`timescale 1ns/10ps
`default_nettype none

module trace_decode import trace_pkg::*; (
   input  wire          trace_clk,
   input  wire          reset,
   input  wire nibble_t trace_data,
   output logic         synced,
   output logic         byte_strobe,
   output byte_t        trace_byte
);

   decode_state_t state;
   logic [27:0]   history;                // previous seven nibbles
   logic [31:0]   window;                 // last eight nibbles incl. current
   logic          phase;                  // 1 = next nibble is the high half
   nibble_t       low_nibble;

   assign window = {history, trace_data};
   assign synced = (state == SYNCED);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state       <= HUNT;
         history     <= '0;
         phase       <= 1'b0;
         byte_strobe <= 1'b0;
      end else begin
         history     <= window[27:0];
         byte_strobe <= 1'b0;

         case (state)
            HUNT: begin
               // sync ends on this nibble, so the next one is a low half
               if (window == SYNC_WORD) begin
                  state <= SYNCED;
                  phase <= 1'b0;
               end
            end

            SYNCED: begin
               phase <= ~phase;
               if (phase) begin
                  byte_strobe <= 1'b1;
               end
            end

            default: state <= HUNT;
         endcase
      end
   end

   // byte assembly, payload only
   always_ff @(posedge trace_clk) begin
      if (state == SYNCED) begin
         if (phase) begin
            trace_byte <= {trace_data, low_nibble};
         end else begin
            low_nibble <= trace_data;
         end
      end
   end

endmodule

`default_nettype wire

//--- pattern_match/pattern_match.sv
/* Sliding buffer of the newest trace bytes compared against a set of masked
   match rules. Flags hits one cycle after each byte and keeps a saturating
   hit count per rule. */

`timescale 1ns/10ps
`default_nettype none

module pattern_match import trace_pkg::*; #(
   parameter int NUM_RULES = 4
) (
   input  wire                               trace_clk,
   input  wire                               reset,
   input  wire                               byte_strobe,
   input  wire byte_t                        trace_byte,
   input  wire match_rule_t [NUM_RULES-1:0]  rules,
   output logic                              hit_strobe,
   output logic [NUM_RULES-1:0]              hit_rules,
   output logic [NUM_RULES-1:0]              trig_rules,
   output hit_count_t [NUM_RULES-1:0]        hit_counts
);

   buffer_t              buffer;
   buffer_t              buffer_next;
   logic [NUM_RULES-1:0] match_vec;       // rules matching the updated buffer
   logic [NUM_RULES-1:0] trig_mask;

   // new byte enters at byte 0, oldest drops out
   assign buffer_next = {buffer[(BUFFER_BYTES-1)*8-1:0], trace_byte};

   always_comb begin
      for (int i = 0; i < NUM_RULES; i++) begin
         match_vec[i] = rules[i].enable &&
                        (((buffer_next ^ rules[i].pattern) & rules[i].mask) == '0);
         trig_mask[i] = rules[i].trig_enable;
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         buffer     <= '0;
         hit_strobe <= 1'b0;
         hit_rules  <= '0;
         trig_rules <= '0;
         hit_counts <= '0;
      end else begin
         hit_strobe <= byte_strobe && (|match_vec);
         hit_rules  <= byte_strobe ? match_vec : '0;
         trig_rules <= byte_strobe ? (match_vec & trig_mask) : '0;

         if (byte_strobe) begin
            buffer <= buffer_next;
            for (int i = 0; i < NUM_RULES; i++) begin
               if (match_vec[i] && (hit_counts[i] != HIT_COUNT_MAX)) begin
                  hit_counts[i] <= hit_counts[i] + 1'b1;   // sticks at 255
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/trigger_pulse.sv
/* Delayed trigger pulse, fired once per arm period by the first hit of a
   rule with trig_enable set. One down counter serves delay and width. */

`timescale 1ns/10ps
`default_nettype none

module trigger_pulse import trace_pkg::*; #(
   parameter int NUM_RULES = 4
) (
   input  wire                       trace_clk,
   input  wire                       reset,
   input  wire                       arm,
   input  wire                       hit_strobe,
   input  wire [NUM_RULES-1:0]       trig_rules,
   input  wire trigger_cfg_t         trig_cfg,
   output logic                      trigger_out
);

   trigger_state_t state;
   logic [15:0]    count;
   logic [15:0]    width_last;            // last count value of the pulse
   logic           fire;

   assign fire        = arm && hit_strobe && (|trig_rules);
   assign width_last  = (trig_cfg.width == '0) ? '0 : trig_cfg.width - 1'b1;
   assign trigger_out = (state == PULSE);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state <= IDLE;
         count <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (fire) begin
                  if (trig_cfg.delay == '0) begin   // pulse starts right away
                     state <= PULSE;
                     count <= width_last;
                  end else begin
                     state <= DELAY;
                     count <= trig_cfg.delay - 1'b1;
                  end
               end
            end

            DELAY: begin
               if (count == '0) begin
                  state <= PULSE;
                  count <= width_last;
               end else begin
                  count <= count - 1'b1;
               end
            end

            PULSE: begin
               if (count == '0) begin
                  state <= DONE;
               end else begin
                  count <= count - 1'b1;
               end
            end

            // wait for arm to drop before the next pulse
            DONE:    if (!arm) state <= IDLE;

            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/capture_record.sv
/* Capture record writer. Counts trace bytes from the rising edge of arm and,
   on a hit while armed, emits the lowest hit rule and the byte position. */

`timescale 1ns/10ps
`default_nettype none

module capture_record import trace_pkg::*; #(
   parameter int NUM_RULES = 4
) (
   input  wire                  trace_clk,
   input  wire                  reset,
   input  wire                  arm,
   input  wire                  byte_strobe,
   input  wire                  hit_strobe,
   input  wire [NUM_RULES-1:0]  hit_rules,
   output logic                 record_valid,
   output record_t              record
);

   logic      arm_q;
   logic      arm_rise;
   position_t position;
   rule_id_t  first_rule;

   assign arm_rise = arm && !arm_q;

   // priority encoder, lowest rule number wins
   always_comb begin
      first_rule = '0;
      for (int i = NUM_RULES - 1; i >= 0; i--) begin
         if (hit_rules[i]) first_rule = rule_id_t'(i);
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         arm_q        <= 1'b0;
         position     <= '0;
         record_valid <= 1'b0;
      end else begin
         arm_q        <= arm;
         record_valid <= hit_strobe && arm;
         if (arm_rise) begin
            position <= position_t'(byte_strobe);  // restart, count this byte
         end else if (arm && byte_strobe) begin
            position <= position + 1'b1;
         end
      end
   end

   // position already holds the hit byte here
   always_ff @(posedge trace_clk) begin
      if (hit_strobe) begin
         record.rule     <= first_rule;
         record.position <= position;
      end
   end

endmodule

`default_nettype wire

//--- verilog/trace_top.sv
/* Top level of the trace capture design: decoder, pattern matcher, trigger
   pulse and capture record, all in the trace_clk domain. Configuration comes
   in as plain input ports. */

`timescale 1ns/10ps
`default_nettype none

module trace_top import trace_pkg::*; #(
   parameter int NUM_RULES = 4            // at most 16
) (
   input  wire                               trace_clk,
   input  wire                               reset,
   input  wire nibble_t                      trace_data,
   input  wire                               arm,
   input  wire match_rule_t [NUM_RULES-1:0]  rules,
   input  wire trigger_cfg_t                 trig_cfg,
   output wire                               synced,
   output wire                               trigger_out,
   output wire                               record_valid,
   output wire record_t                      record,
   output wire hit_count_t [NUM_RULES-1:0]   hit_counts
);

   logic                 byte_strobe;
   byte_t                trace_byte;
   logic                 hit_strobe;
   logic [NUM_RULES-1:0] hit_rules;
   logic [NUM_RULES-1:0] trig_rules;

   trace_decode u_decode (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .trace_data  (trace_data),
      .synced      (synced),
      .byte_strobe (byte_strobe),
      .trace_byte  (trace_byte)
   );

   pattern_match #(
      .NUM_RULES   (NUM_RULES)
   ) u_match (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .byte_strobe (byte_strobe),
      .trace_byte  (trace_byte),
      .rules       (rules),
      .hit_strobe  (hit_strobe),
      .hit_rules   (hit_rules),
      .trig_rules  (trig_rules),
      .hit_counts  (hit_counts)
   );

   trigger_pulse #(
      .NUM_RULES   (NUM_RULES)
   ) u_trigger (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .arm         (arm),
      .hit_strobe  (hit_strobe),
      .trig_rules  (trig_rules),
      .trig_cfg    (trig_cfg),
      .trigger_out (trigger_out)
   );

   capture_record #(
      .NUM_RULES    (NUM_RULES)
   ) u_record (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .arm          (arm),
      .byte_strobe  (byte_strobe),
      .hit_strobe   (hit_strobe),
      .hit_rules    (hit_rules),
      .record_valid (record_valid),
      .record       (record)
   );

endmodule

`default_nettype wire

//--- verification/trace_tb_tasks.svh
/* Stimulus tasks for the trace capture testbench, included inside trace_tb.
   Each task drives the trace port and updates the reference model. */

`ifndef TRACE_TB_TASKS_SVH
`define TRACE_TB_TASKS_SVH

// one nibble on the port, s returns the edge where the DUT samples it
task automatic drive_nibble(input nibble_t n, input bit hi, output int s);
   @(posedge trace_clk);
   s = cycle + 2;
   trace_data <= n;
   if (hi || !synced_m) begin            // config moves with high nibbles once synced
      arm      <= arm_m;
      rules    <= rule_cfg;
      trig_cfg <= trig_m;
   end
   if (!synced_m) begin
      if ({hist_m[27:0], n} == SYNC_WORD) begin
         synced_m   = 1'b1;
         sync_cycle = s;
      end
      hist_m = {hist_m[27:0], n};
   end
endtask

task automatic send_sync();
   int s;
   for (int i = 0; i < 8; i++) begin
      drive_nibble(SYNC_WORD[31-4*i -: 4], 1'b0, s);
   end
endtask

task automatic send_random_nibbles(input int count);
   nibble_t n;
   int      s;
   for (int i = 0; i < count; i++) begin
      n = nibble_t'($urandom % 15);
      if (n >= 4'd7) n = n + 1'b1;          // never a 7, so no sync can form
      drive_nibble(n, 1'b0, s);
   end
endtask

// arm level changes together with the high nibble
task automatic update_arm(input bit a);
   resolve_hit(a);
   if (a && !arm_m) pos_m = '0;
   if (!a && arm_m) trig_done_m = 1'b0;
   arm_m = a;
endtask

task automatic send_byte(input byte_t b, input bit a);
   int s;
   drive_nibble(b[3:0], 1'b0, s);
   update_arm(a);
   drive_nibble(b[7:4], 1'b1, s);
   expect_byte(b, s);
endtask

task automatic send_bytes(input byte_t b, input int count, input bit a);
   for (int i = 0; i < count; i++) begin
      send_byte(b, a);
   end
endtask

`endif

//--- verification/trace_tb.sv
/* Testbench for trace_top. Drives the nibble port through sync, masked
   matches, arm periods and counter saturation against a reference model. */

`timescale 1ns/10ps
`default_nettype none

module trace_tb;
   import trace_pkg::*;

   localparam int NUM_RULES = 4;
   localparam int TIMEOUT_CYCLES = 3000;   // tests need about 1100

   logic                             trace_clk;
   logic                             reset;
   nibble_t                          trace_data;
   logic                             arm;
   match_rule_t [NUM_RULES-1:0]      rules;
   trigger_cfg_t                     trig_cfg;
   logic                             synced;
   logic                             trigger_out;
   logic                             record_valid;
   record_t                          record;
   hit_count_t [NUM_RULES-1:0]       hit_counts;

   int cycle = 0;
   int errors = 0;

   // reference model state
   logic [31:0]                 hist_m = '0;
   bit                          synced_m = 1'b0;
   int                          sync_cycle = -1;
   buffer_t                     buf_m = '0;
   bit                          arm_m = 1'b0;
   position_t                   pos_m = '0;
   bit                          trig_done_m = 1'b0;
   hit_count_t [NUM_RULES-1:0]  counts_m = '0;
   match_rule_t [NUM_RULES-1:0] rule_cfg = '0;
   trigger_cfg_t                trig_m = '0;

   // last byte's hit, waiting for the arm level of its strobe cycle
   bit                          pend_hit = 1'b0;
   bit                          pend_trig = 1'b0;
   int                          pend_s = 0;
   rule_id_t                    pend_rule = '0;
   position_t                   pend_pos = '0;

   // expected outputs keyed by cycle
   bit                          exp_valid[int];
   rule_id_t                    exp_rule[int];
   position_t                   exp_pos[int];
   bit                          exp_trig[int];
   hit_count_t [NUM_RULES-1:0]  evt_counts[int];
   hit_count_t [NUM_RULES-1:0]  shown_counts = '0;

   trace_top #(
      .NUM_RULES    (NUM_RULES)
   ) dut0 (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .trace_data   (trace_data),
      .arm          (arm),
      .rules        (rules),
      .trig_cfg     (trig_cfg),
      .synced       (synced),
      .trigger_out  (trigger_out),
      .record_valid (record_valid),
      .record       (record),
      .hit_counts   (hit_counts)
   );

   initial begin
      trace_clk = 1'b0;
      forever #20 trace_clk = ~trace_clk;
   end

   always @(posedge trace_clk) cycle <= cycle + 1;

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   // byte sampled at edge s: counts show at s+1, record at s+2, pulse at s+2+delay
   task automatic expect_byte(input byte_t b, input int s);
      logic [NUM_RULES-1:0] hits;
      buf_m = {buf_m[23:0], b};
      if (arm_m) pos_m = pos_m + 1'b1;
      pend_hit  = 1'b0;
      pend_trig = 1'b0;
      pend_s    = s;
      pend_pos  = pos_m;
      for (int i = 0; i < NUM_RULES; i++) begin
         hits[i] = rule_cfg[i].enable &&
                   ((buf_m & rule_cfg[i].mask) == (rule_cfg[i].pattern & rule_cfg[i].mask));
         if (hits[i] && counts_m[i] != 8'd255) counts_m[i] = counts_m[i] + 1'b1;
         if (hits[i] && !pend_hit) pend_rule = rule_id_t'(i);   // lowest hit rule
         if (hits[i]) pend_hit = 1'b1;
         if (hits[i] && rule_cfg[i].trig_enable) pend_trig = 1'b1;
      end
      evt_counts[s+1] = counts_m;
   endtask

   // hit strobe cycle already carries the arm level of the next byte
   task automatic resolve_hit(input bit a);
      int w;
      if (pend_hit && a) begin
         exp_valid[pend_s+2] = 1'b1;
         exp_rule[pend_s+2]  = pend_rule;
         exp_pos[pend_s+2]   = pend_pos;
      end
      if (pend_trig && a && !trig_done_m) begin
         trig_done_m = 1'b1;
         w = (trig_m.width == '0) ? 1 : int'(trig_m.width);
         for (int k = 0; k < w; k++) exp_trig[pend_s + 2 + int'(trig_m.delay) + k] = 1'b1;
      end
      pend_hit  = 1'b0;
      pend_trig = 1'b0;
   endtask

   `include "trace_tb_tasks.svh"

   always @(negedge trace_clk) begin
      if (!reset) begin
         if (evt_counts.exists(cycle)) shown_counts = evt_counts[cycle];
         assert (hit_counts == shown_counts)
            else report_error($sformatf("hit_counts %h, expected %h", hit_counts, shown_counts));
         assert (synced == (sync_cycle >= 0 && cycle >= sync_cycle))
            else report_error($sformatf("synced is %0b at cycle %0d", synced, cycle));
         assert (record_valid == exp_valid.exists(cycle))
            else report_error($sformatf("record_valid is %0b at cycle %0d", record_valid, cycle));
         if (exp_valid.exists(cycle)) begin
            assert (record.rule == exp_rule[cycle] && record.position == exp_pos[cycle])
               else report_error($sformatf("record rule %0d pos %0d, expected %0d pos %0d",
                  record.rule, record.position, exp_rule[cycle], exp_pos[cycle]));
         end
         assert (trigger_out == exp_trig.exists(cycle))
            else report_error($sformatf("trigger_out is %0b at cycle %0d", trigger_out, cycle));
      end
   end

   // no record can appear before sync
   assert property (@(posedge trace_clk) disable iff (reset) record_valid |-> synced)
      else report_error("record_valid while not synced");

   always @(posedge trace_clk) begin
      if (cycle >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      void'($urandom(10865));
      reset      = 1'b1;
      trace_data = '0;
      arm        = 1'b0;
      rules      = '0;
      trig_cfg   = '0;
      repeat (4) @(posedge trace_clk);
      reset <= 1'b0;

      // match-all rule, armed, but no sync yet
      rule_cfg[0].enable = 1'b1;
      arm_m = 1'b1;
      send_random_nibbles(200);
      assert (!synced) else report_error("synced rose on random data");

      rule_cfg = '0;
      arm_m    = 1'b0;
      rule_cfg[0].pattern = 32'h1122_3344;
      rule_cfg[0].mask    = 32'hffff_ffff;
      rule_cfg[0].enable  = 1'b1;
      send_sync();
      send_byte(8'h11, 1'b1);
      send_bytes(8'h22, 1, 1'b1);
      send_bytes(8'h33, 1, 1'b1);
      send_bytes(8'h44, 1, 1'b1);
      send_bytes(8'h00, 4, 1'b1);
      send_byte(8'h11, 1'b1);
      send_byte(8'h22, 1'b1);
      send_byte(8'h33, 1'b1);
      send_byte(8'h45, 1'b1);              // one byte off

      // partial mask on rule 1, exact rule 2 overlapping it
      rule_cfg[1].pattern = 32'h0000_00a0;
      rule_cfg[1].mask    = 32'h0000_00f0;
      rule_cfg[1].enable  = 1'b1;
      rule_cfg[2].pattern = 32'h0000_00a5;
      rule_cfg[2].mask    = 32'h0000_00ff;
      rule_cfg[2].enable  = 1'b1;
      send_byte(8'h00, 1'b1);
      send_byte(8'ha3, 1'b1);
      send_byte(8'ha9, 1'b1);
      send_byte(8'ha5, 1'b1);
      send_byte(8'h00, 1'b1);              // arm held through the hit strobe

      // fresh arm period for the position count
      send_bytes(8'h00, 2, 1'b0);
      send_bytes(8'h00, 5, 1'b1);
      send_byte(8'ha5, 1'b1);
      send_byte(8'h00, 1'b1);

      // trigger, one pulse per arm period
      trig_m.delay = 16'd5;
      trig_m.width = 16'd3;
      rule_cfg[2].trig_enable = 1'b1;
      send_bytes(8'h00, 2, 1'b0);
      send_byte(8'ha5, 1'b1);
      send_bytes(8'h00, 8, 1'b1);
      send_byte(8'ha5, 1'b1);
      send_bytes(8'h00, 8, 1'b1);
      send_bytes(8'h00, 2, 1'b0);
      send_byte(8'ha5, 1'b1);
      send_bytes(8'h00, 8, 1'b1);
      send_bytes(8'h00, 2, 1'b0);
      send_byte(8'h11, 1'b0);
      send_byte(8'h22, 1'b0);
      send_byte(8'h33, 1'b0);
      send_byte(8'h44, 1'b0);
      send_byte(8'ha5, 1'b0);

      // counter saturation on rule 1
      send_bytes(8'ha9, 300, 1'b0);
      send_bytes(8'h00, 20, 1'b0);
      assert (hit_counts[1] == 8'd255)
         else report_error($sformatf("rule 1 count %0d, expected 255", hit_counts[1]));

      $display("run complete after %0d cycles, %0d errors", cycle, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+verification
common/trace_pkg.sv
trace_decode/trace_decode.sv
pattern_match/pattern_match.sv
verilog/trigger_pulse.sv
verilog/capture_record.sv
verilog/trace_top.sv
verification/trace_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = trace_tb
FILE_LIST = list.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)
